// ==== source/rv_pkg.sv ====
package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [7:0]  mem_addr_t;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // major opcodes
    localparam opcode_t OP_ALG     = 7'b0110011;
    localparam opcode_t OP_ALG64   = 7'b0111011;
    localparam opcode_t OP_ALG_IMM = 7'b0010011;
    localparam opcode_t OP_LOAD    = 7'b0000011;
    localparam opcode_t OP_BRANCH  = 7'b1100011;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h00000013;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

endpackage

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
    input  logic              CLK,
    input  logic              reset,
    input  logic              run_i,
    input  logic              load_en_i,
    input  logic              load_dmem_i,
    input  rv_pkg::mem_addr_t load_addr_i,
    input  rv_pkg::xlen_t     load_data_i,
    input  logic              stall_i,
    input  logic              redirect_i,
    input  rv_pkg::xlen_t     redirect_pc_i,
    output rv_pkg::inst_t     inst_o,
    output rv_pkg::xlen_t     pc_o
);

    rv_pkg::inst_t     imem [rv_pkg::IMEM_DEPTH];
    rv_pkg::xlen_t     pc_q;
    rv_pkg::mem_addr_t fetch_idx;

    // word index into instruction memory
    assign fetch_idx = pc_q[9:2];

    always_ff @(posedge CLK) begin
        if (load_en_i && !load_dmem_i) begin
            imem[load_addr_i] <= load_data_i[31:0];
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            pc_q   <= '0;
            pc_o   <= '0;
            inst_o <= rv_pkg::NOP_INST;
        end else if (!run_i) begin
            inst_o <= rv_pkg::NOP_INST;
        end else if (redirect_i) begin
            // taken branch, drop the word in flight
            pc_q   <= redirect_pc_i;
            inst_o <= rv_pkg::NOP_INST;
        end else if (!stall_i) begin
            inst_o <= imem[fetch_idx];
            pc_o   <= pc_q;
            pc_q   <= pc_q + 64'd4;
        end
    end

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic              CLK,
    input  logic              reset,
    input  rv_pkg::inst_t     inst_i,
    input  rv_pkg::xlen_t     pc_i,
    input  logic              flush_i,
    input  logic              wb_en_i,
    input  rv_pkg::reg_idx_t  wb_rd_i,
    input  rv_pkg::xlen_t     wb_value_i,
    input  logic              ex_load_i,
    input  rv_pkg::reg_idx_t  ex_rd_i,
    output logic              stall_o,
    output logic              de_valid_o,
    output rv_pkg::reg_idx_t  de_rd_o,
    output rv_pkg::reg_idx_t  de_rs1_o,
    output rv_pkg::reg_idx_t  de_rs2_o,
    output rv_pkg::xlen_t     de_op1_o,
    output rv_pkg::xlen_t     de_op2_o,
    output logic              de_imm_flag_o,
    output rv_pkg::alu_op_e   de_alu_op_o,
    output logic              de_word_o,
    output logic              de_load_o,
    output logic              de_branch_o,
    output logic [2:0]        de_funct3_o,
    output rv_pkg::xlen_t     de_branch_offset_o,
    output rv_pkg::xlen_t     de_pc_o,
    output logic              de_write_back_o
);

    rv_pkg::xlen_t    regs [32];
    rv_pkg::opcode_t  opcode;
    rv_pkg::reg_idx_t rd_idx;
    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    logic [2:0]       funct3;
    logic             is_alg;
    logic             is_alg64;
    logic             is_imm;
    logic             is_load;
    logic             is_branch;
    logic             uses_rs2;
    logic             write_back;
    rv_pkg::xlen_t    imm_i;
    rv_pkg::xlen_t    imm_b;
    rv_pkg::xlen_t    rs1_val;
    rv_pkg::xlen_t    rs2_val;
    rv_pkg::alu_op_e  alu_op;
    rv_pkg::xlen_t    op1_q;
    rv_pkg::xlen_t    op2_q;

    assign opcode = inst_i[6:0];
    assign rd_idx = inst_i[11:7];
    assign funct3 = inst_i[14:12];

    assign is_alg    = opcode == rv_pkg::OP_ALG;
    assign is_alg64  = opcode == rv_pkg::OP_ALG64;
    assign is_imm    = opcode == rv_pkg::OP_ALG_IMM;
    assign is_load   = opcode == rv_pkg::OP_LOAD && funct3 == 3'b011;
    assign is_branch = opcode == rv_pkg::OP_BRANCH && funct3[2:1] != 2'b01;
    assign uses_rs2  = is_alg || is_alg64 || is_branch;

    // unused sources read as x0 so they never match a hazard
    assign rs1_idx = (uses_rs2 || is_imm || is_load) ? inst_i[19:15] : '0;
    assign rs2_idx = uses_rs2 ? inst_i[24:20] : '0;

    // x0 writes are dropped here already
    assign write_back = (is_alg || is_alg64 || is_imm || is_load) && rd_idx != '0;

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign stall_o = ex_load_i && ex_rd_i != '0 && (rs1_idx == ex_rd_i || rs2_idx == ex_rd_i);

    always_comb begin
        alu_op = rv_pkg::ADD;
        if (is_alg || is_alg64 || is_imm) begin
            case (funct3)
                3'b000: alu_op = (inst_i[30] && !is_imm) ? rv_pkg::SUB : rv_pkg::ADD;
                3'b001: alu_op = rv_pkg::SLL;
                3'b010: alu_op = rv_pkg::SLT;
                3'b011: alu_op = rv_pkg::SLTU;
                3'b100: alu_op = rv_pkg::XOR;
                3'b101: alu_op = inst_i[30] ? rv_pkg::SRA : rv_pkg::SRL;
                3'b110: alu_op = rv_pkg::OR;
                default: alu_op = rv_pkg::AND;
            endcase
        end
    end

    // operand read with same-cycle writeback bypass
    always_comb begin
        rs1_val = regs[rs1_idx];
        rs2_val = regs[rs2_idx];
        if (wb_en_i && wb_rd_i == rs1_idx) begin
            rs1_val = wb_value_i;
        end
        if (wb_en_i && wb_rd_i == rs2_idx) begin
            rs2_val = wb_value_i;
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_value_i;
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            de_valid_o      <= 1'b0;
            de_write_back_o <= 1'b0;
            de_load_o       <= 1'b0;
            de_branch_o     <= 1'b0;
        end else begin
            // bubble on load-use hazard or taken branch
            de_valid_o      <= !(stall_o || flush_i);
            de_write_back_o <= write_back;
            de_load_o       <= is_load;
            de_branch_o     <= is_branch;
        end
    end

    always_ff @(posedge CLK) begin
        de_rd_o            <= rd_idx;
        de_rs1_o           <= rs1_idx;
        de_rs2_o           <= rs2_idx;
        op1_q              <= rs1_val;
        op2_q              <= (is_imm || is_load) ? imm_i : rs2_val;
        de_imm_flag_o      <= is_imm || is_load;
        de_alu_op_o        <= alu_op;
        de_word_o          <= is_alg64;
        de_funct3_o        <= funct3;
        de_branch_offset_o <= imm_b;
        de_pc_o            <= pc_i;
    end

    // result two ahead sits in wb while this one executes
    assign de_op1_o = (wb_en_i && de_rs1_o != '0 && wb_rd_i == de_rs1_o) ? wb_value_i : op1_q;
    assign de_op2_o = (wb_en_i && !de_imm_flag_o && de_rs2_o != '0 && wb_rd_i == de_rs2_o)
                    ? wb_value_i : op2_q;

endmodule

// ==== source/inst_execute.sv ====
`timescale 1ns/1ps

module inst_execute (
    input  logic              CLK,
    input  logic              reset,
    input  logic              de_valid_i,
    input  rv_pkg::reg_idx_t  de_rd_i,
    input  rv_pkg::reg_idx_t  de_rs1_i,
    input  rv_pkg::reg_idx_t  de_rs2_i,
    input  rv_pkg::xlen_t     de_op1_i,
    input  rv_pkg::xlen_t     de_op2_i,
    input  logic              de_imm_flag_i,
    input  rv_pkg::alu_op_e   de_alu_op_i,
    input  logic              de_word_i,
    input  logic              de_load_i,
    input  logic              de_branch_i,
    input  logic [2:0]        de_funct3_i,
    input  rv_pkg::xlen_t     de_branch_offset_i,
    input  rv_pkg::xlen_t     de_pc_i,
    input  logic              de_write_back_i,
    output logic              redirect_o,
    output rv_pkg::xlen_t     redirect_pc_o,
    output logic              ex_load_o,
    output rv_pkg::reg_idx_t  ex_rd_o,
    output logic              em_valid_o,
    output rv_pkg::reg_idx_t  em_rd_o,
    output rv_pkg::xlen_t     em_result_o,
    output logic              em_load_o,
    output logic              em_write_back_o
);

    logic          fwd_ok;
    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t a_srl;
    rv_pkg::xlen_t a_sra;
    logic [5:0]    shamt;
    rv_pkg::xlen_t alu_raw;
    rv_pkg::xlen_t result;
    logic          taken;

    // only ALU writers in em can forward, loads were stalled for
    assign fwd_ok = em_valid_o && em_write_back_o && !em_load_o && em_rd_o != '0;
    assign op_a = (fwd_ok && em_rd_o == de_rs1_i) ? em_result_o : de_op1_i;
    assign op_b = (fwd_ok && !de_imm_flag_i && em_rd_o == de_rs2_i) ? em_result_o : de_op2_i;

    assign shamt = de_word_i ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign a_srl = de_word_i ? {32'b0, op_a[31:0]} : op_a;
    assign a_sra = de_word_i ? {{32{op_a[31]}}, op_a[31:0]} : op_a;

    always_comb begin
        case (de_alu_op_i)
            rv_pkg::ADD:  alu_raw = op_a + op_b;
            rv_pkg::SUB:  alu_raw = op_a - op_b;
            rv_pkg::SLL:  alu_raw = op_a << shamt;
            rv_pkg::SLT:  alu_raw = {63'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU: alu_raw = {63'b0, op_a < op_b};
            rv_pkg::XOR:  alu_raw = op_a ^ op_b;
            rv_pkg::SRL:  alu_raw = a_srl >> shamt;
            rv_pkg::SRA:  alu_raw = $signed(a_sra) >>> shamt;
            rv_pkg::OR:   alu_raw = op_a | op_b;
            default:      alu_raw = op_a & op_b;
        endcase
    end

    // W forms keep the low word, sign extended
    assign result = de_word_i ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

    always_comb begin
        case (de_funct3_i)
            3'b000:  taken = op_a == op_b;
            3'b001:  taken = op_a != op_b;
            3'b100:  taken = $signed(op_a) < $signed(op_b);
            3'b101:  taken = $signed(op_a) >= $signed(op_b);
            3'b110:  taken = op_a < op_b;
            3'b111:  taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = de_valid_i && de_branch_i && taken;
    assign redirect_pc_o = de_pc_i + de_branch_offset_i;

    assign ex_load_o = de_valid_i && de_load_i;
    assign ex_rd_o   = de_rd_i;

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            em_valid_o      <= 1'b0;
            em_load_o       <= 1'b0;
            em_write_back_o <= 1'b0;
        end else begin
            em_valid_o      <= de_valid_i;
            em_load_o       <= de_valid_i && de_load_i;
            em_write_back_o <= de_valid_i && de_write_back_i;
        end
    end

    always_ff @(posedge CLK) begin
        em_rd_o     <= de_rd_i;
        em_result_o <= result;
    end

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic              CLK,
    input  logic              reset,
    input  logic              load_en_i,
    input  logic              load_dmem_i,
    input  rv_pkg::mem_addr_t load_addr_i,
    input  rv_pkg::xlen_t     load_data_i,
    input  logic              em_valid_i,
    input  rv_pkg::reg_idx_t  em_rd_i,
    input  rv_pkg::xlen_t     em_result_i,
    input  logic              em_load_i,
    input  logic              em_write_back_i,
    output logic              wb_en_o,
    output rv_pkg::reg_idx_t  wb_rd_o,
    output rv_pkg::xlen_t     wb_value_o
);

    rv_pkg::xlen_t     dmem [rv_pkg::DMEM_DEPTH];
    rv_pkg::mem_addr_t rd_addr;

    // byte address, 8-byte words
    assign rd_addr = em_result_i[10:3];

    always_ff @(posedge CLK) begin
        if (load_en_i && load_dmem_i) begin
            dmem[load_addr_i] <= load_data_i;
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= em_valid_i && em_write_back_i;
        end
    end

    always_ff @(posedge CLK) begin
        wb_rd_o    <= em_rd_i;
        wb_value_o <= em_load_i ? dmem[rd_addr] : em_result_i;
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic              CLK,
    input  logic              reset,
    input  logic              run_i,
    input  logic              load_en_i,
    input  logic              load_dmem_i,
    input  rv_pkg::mem_addr_t load_addr_i,
    input  rv_pkg::xlen_t     load_data_i,
    output logic              wb_en_o,
    output rv_pkg::reg_idx_t  wb_rd_o,
    output rv_pkg::xlen_t     wb_value_o
);

    rv_pkg::inst_t    fd_inst;
    rv_pkg::xlen_t    fd_pc;
    logic             stall;
    logic             redirect;
    rv_pkg::xlen_t    redirect_pc;

    logic             de_valid;
    rv_pkg::reg_idx_t de_rd;
    rv_pkg::reg_idx_t de_rs1;
    rv_pkg::reg_idx_t de_rs2;
    rv_pkg::xlen_t    de_op1;
    rv_pkg::xlen_t    de_op2;
    logic             de_imm_flag;
    rv_pkg::alu_op_e  de_alu_op;
    logic             de_word;
    logic             de_load;
    logic             de_branch;
    logic [2:0]       de_funct3;
    rv_pkg::xlen_t    de_branch_offset;
    rv_pkg::xlen_t    de_pc;
    logic             de_write_back;

    logic             ex_load;
    rv_pkg::reg_idx_t ex_rd;

    logic             em_valid;
    rv_pkg::reg_idx_t em_rd;
    rv_pkg::xlen_t    em_result;
    logic             em_load;
    logic             em_write_back;

    inst_fetch i_inst_fetch (
        .CLK           (CLK),
        .reset         (reset),
        .run_i         (run_i),
        .load_en_i     (load_en_i),
        .load_dmem_i   (load_dmem_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_o        (fd_inst),
        .pc_o          (fd_pc)
    );

    inst_decode i_inst_decode (
        .CLK                (CLK),
        .reset              (reset),
        .inst_i             (fd_inst),
        .pc_i               (fd_pc),
        .flush_i            (redirect),
        .wb_en_i            (wb_en_o),
        .wb_rd_i            (wb_rd_o),
        .wb_value_i         (wb_value_o),
        .ex_load_i          (ex_load),
        .ex_rd_i            (ex_rd),
        .stall_o            (stall),
        .de_valid_o         (de_valid),
        .de_rd_o            (de_rd),
        .de_rs1_o           (de_rs1),
        .de_rs2_o           (de_rs2),
        .de_op1_o           (de_op1),
        .de_op2_o           (de_op2),
        .de_imm_flag_o      (de_imm_flag),
        .de_alu_op_o        (de_alu_op),
        .de_word_o          (de_word),
        .de_load_o          (de_load),
        .de_branch_o        (de_branch),
        .de_funct3_o        (de_funct3),
        .de_branch_offset_o (de_branch_offset),
        .de_pc_o            (de_pc),
        .de_write_back_o    (de_write_back)
    );

    inst_execute i_inst_execute (
        .CLK                (CLK),
        .reset              (reset),
        .de_valid_i         (de_valid),
        .de_rd_i            (de_rd),
        .de_rs1_i           (de_rs1),
        .de_rs2_i           (de_rs2),
        .de_op1_i           (de_op1),
        .de_op2_i           (de_op2),
        .de_imm_flag_i      (de_imm_flag),
        .de_alu_op_i        (de_alu_op),
        .de_word_i          (de_word),
        .de_load_i          (de_load),
        .de_branch_i        (de_branch),
        .de_funct3_i        (de_funct3),
        .de_branch_offset_i (de_branch_offset),
        .de_pc_i            (de_pc),
        .de_write_back_i    (de_write_back),
        .redirect_o         (redirect),
        .redirect_pc_o      (redirect_pc),
        .ex_load_o          (ex_load),
        .ex_rd_o            (ex_rd),
        .em_valid_o         (em_valid),
        .em_rd_o            (em_rd),
        .em_result_o        (em_result),
        .em_load_o          (em_load),
        .em_write_back_o    (em_write_back)
    );

    data_memory i_data_memory (
        .CLK             (CLK),
        .reset           (reset),
        .load_en_i       (load_en_i),
        .load_dmem_i     (load_dmem_i),
        .load_addr_i     (load_addr_i),
        .load_data_i     (load_data_i),
        .em_valid_i      (em_valid),
        .em_rd_i         (em_rd),
        .em_result_i     (em_result),
        .em_load_i       (em_load),
        .em_write_back_i (em_write_back),
        .wb_en_o         (wb_en_o),
        .wb_rd_o         (wb_rd_o),
        .wb_value_o      (wb_value_o)
    );

endmodule

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam int PROG_MAX  = 96;
    localparam int NUM_TESTS = 6;

    logic              CLK;
    logic              reset;
    logic              run_i;
    logic              load_en_i;
    logic              load_dmem_i;
    rv_pkg::mem_addr_t load_addr_i;
    rv_pkg::xlen_t     load_data_i;
    logic              wb_en_o;
    rv_pkg::reg_idx_t  wb_rd_o;
    rv_pkg::xlen_t     wb_value_o;

    rv_pkg::inst_t    prog [PROG_MAX];
    int               prog_test [PROG_MAX];
    int               prog_len;
    int               cur_test;
    rv_pkg::xlen_t    data_words [rv_pkg::DMEM_DEPTH];
    rv_pkg::reg_idx_t exp_rd [$];
    rv_pkg::xlen_t    exp_value [$];
    int               exp_test [$];
    string            test_names [NUM_TESTS];
    int               test_total [NUM_TESTS];
    int               test_seen [NUM_TESTS];
    int               test_errors [NUM_TESTS];
    logic [31:0]      seed;
    int               exp_idx = 0;
    int               checks = 0;
    int               errors = 0;
    int               cycles = 0;
    int               limit;
    logic             timed_out;

    rv_core i_rv_core (
        .CLK         (CLK),
        .reset       (reset),
        .run_i       (run_i),
        .load_en_i   (load_en_i),
        .load_dmem_i (load_dmem_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .wb_en_o     (wb_en_o),
        .wb_rd_o     (wb_rd_o),
        .wb_value_o  (wb_value_o)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic rv_pkg::inst_t enc_r(input rv_pkg::opcode_t op, input logic [2:0] f3,
                                            input logic [6:0] f7, input int rd, input int rs1,
                                            input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv_pkg::inst_t enc_i(input rv_pkg::opcode_t op, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv_pkg::inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                            input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    endfunction

    // reference ALU straight from the ISA rules
    function automatic rv_pkg::xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                                input rv_pkg::xlen_t a, input rv_pkg::xlen_t b,
                                                input logic word);
        rv_pkg::xlen_t y;
        logic [31:0]   lo;
        y = '0;
        lo = '0;
        if (word) begin
            if (f3 == 3'b000) begin
                lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            end else if (f3 == 3'b001) begin
                lo = a[31:0] << b[4:0];
            end else if (alt) begin
                lo = $signed(a[31:0]) >>> b[4:0];
            end else begin
                lo = a[31:0] >> b[4:0];
            end
            y = {{32{lo[31]}}, lo};
        end else begin
            case (f3)
                3'b000: y = alt ? a - b : a + b;
                3'b001: y = a << b[5:0];
                3'b010: y = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'b011: y = (a < b) ? 64'd1 : 64'd0;
                3'b100: y = a ^ b;
                3'b101: begin
                    if (alt) begin
                        y = $signed(a) >>> b[5:0];
                    end else begin
                        y = a >> b[5:0];
                    end
                end
                3'b110: y = a | b;
                default: y = a & b;
            endcase
        end
        return y;
    endfunction

    task automatic emit(input rv_pkg::inst_t inst);
        prog[prog_len] = inst;
        prog_test[prog_len] = cur_test;
        prog_len = prog_len + 1;
    endtask

    task automatic build_program();
        for (int i = 0; i < PROG_MAX; i++) begin
            prog[i] = rv_pkg::NOP_INST;
        end
        test_names[0] = "alu chains";
        test_names[1] = "w forms";
        test_names[2] = "load use";
        test_names[3] = "branches";
        test_names[4] = "x0 writes";
        test_names[5] = "completion";
        prog_len = 0;
        cur_test = 0;
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 1, 0, 100));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 2, 1, -7));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h00, 3, 1, 2));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h20, 4, 3, 1));
        emit(enc_r(rv_pkg::OP_ALG, 3'b100, 7'h00, 5, 4, 3));
        emit(enc_r(rv_pkg::OP_ALG, 3'b110, 7'h00, 6, 5, 2));
        emit(enc_r(rv_pkg::OP_ALG, 3'b111, 7'h00, 7, 6, 3));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b001, 8, 7, 56));
        // srai, funct7 bit set in the immediate
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b101, 9, 8, 1027));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b101, 10, 8, 4));
        emit(enc_r(rv_pkg::OP_ALG, 3'b010, 7'h00, 11, 9, 1));
        emit(enc_r(rv_pkg::OP_ALG, 3'b011, 7'h00, 12, 9, 1));
        emit(enc_r(rv_pkg::OP_ALG, 3'b001, 7'h00, 13, 1, 2));
        emit(enc_r(rv_pkg::OP_ALG, 3'b101, 7'h20, 14, 9, 2));
        emit(enc_r(rv_pkg::OP_ALG, 3'b101, 7'h00, 15, 9, 2));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b111, 16, 9, 2032));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b100, 17, 1, -1));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b010, 18, 17, 0));
        cur_test = 1;
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 20, 0, 2047));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b001, 20, 20, 20));
        emit(enc_r(rv_pkg::OP_ALG64, 3'b000, 7'h00, 21, 20, 20));
        emit(enc_r(rv_pkg::OP_ALG64, 3'b000, 7'h20, 22, 0, 20));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 23, 0, 36));
        emit(enc_r(rv_pkg::OP_ALG64, 3'b001, 7'h00, 24, 20, 23));
        emit(enc_r(rv_pkg::OP_ALG64, 3'b101, 7'h20, 25, 21, 23));
        emit(enc_r(rv_pkg::OP_ALG64, 3'b101, 7'h00, 26, 21, 23));
        cur_test = 2;
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 26, 0, 0));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h00, 27, 26, 1));
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 28, 0, 8));
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 29, 0, 16));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h20, 30, 29, 28));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 18, 0, 24));
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 19, 18, 8));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h00, 31, 19, 27));
        cur_test = 3;
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 10, 0, -5));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 11, 0, 7));
        // one taken and one not-taken pair per condition
        for (int k = 0; k < 12; k++) begin
            case (k)
                0: emit(enc_b(3'b000, 11, 11, 8));
                1: emit(enc_b(3'b000, 10, 11, 8));
                2: emit(enc_b(3'b001, 10, 11, 8));
                3: emit(enc_b(3'b001, 11, 11, 8));
                4: emit(enc_b(3'b100, 10, 11, 8));
                5: emit(enc_b(3'b100, 11, 10, 8));
                6: emit(enc_b(3'b101, 11, 10, 8));
                7: emit(enc_b(3'b101, 10, 11, 8));
                8: emit(enc_b(3'b110, 11, 10, 8));
                9: emit(enc_b(3'b110, 10, 11, 8));
                10: emit(enc_b(3'b111, 10, 11, 8));
                default: emit(enc_b(3'b111, 11, 10, 8));
            endcase
            emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 12, 0, k + 1));
        end
        // short countdown loop, backward branch
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 13, 0, 3));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 13, 13, -1));
        emit(enc_b(3'b001, 13, 0, -4));
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 14, 0, 0));
        emit(enc_b(3'b000, 14, 14, 8));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 15, 0, 99));
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 15, 0, 42));
        cur_test = 4;
        emit(enc_i(rv_pkg::OP_ALG_IMM, 3'b000, 0, 0, 55));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h00, 0, 1, 2));
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 0, 0, 0));
        emit(enc_r(rv_pkg::OP_ALG, 3'b000, 7'h00, 16, 0, 1));
        emit(enc_r(rv_pkg::OP_ALG, 3'b110, 7'h00, 17, 0, 0));
        // park on a branch to itself
        emit(enc_b(3'b000, 0, 0, 0));
    endtask

    // step through the program and collect the writebacks it must produce
    task automatic build_expected();
        rv_pkg::xlen_t   r [32];
        rv_pkg::inst_t   w;
        rv_pkg::opcode_t op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      f3;
        rv_pkg::xlen_t   a;
        rv_pkg::xlen_t   b;
        rv_pkg::xlen_t   imm;
        rv_pkg::xlen_t   res;
        rv_pkg::xlen_t   addr;
        logic            wr;
        logic            taken;
        logic            done;
        int              pc_idx;
        int              next_idx;
        int              boff;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_total[t] = 0;
        end
        pc_idx = 0;
        steps = 0;
        done = 1'b0;
        while (!done && pc_idx < prog_len && steps < 1000) begin
            w = prog[pc_idx];
            op = w[6:0];
            rd = w[11:7];
            f3 = w[14:12];
            rs1 = w[19:15];
            rs2 = w[24:20];
            a = r[rs1];
            b = r[rs2];
            imm = {{52{w[31]}}, w[31:20]};
            boff = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            wr = 1'b0;
            taken = 1'b0;
            res = '0;
            next_idx = pc_idx + 1;
            case (op)
                rv_pkg::OP_ALG: begin
                    res = alu_model(f3, w[30], a, b, 1'b0);
                    wr = 1'b1;
                end
                rv_pkg::OP_ALG64: begin
                    res = alu_model(f3, w[30], a, b, 1'b1);
                    wr = 1'b1;
                end
                rv_pkg::OP_ALG_IMM: begin
                    res = alu_model(f3, f3 == 3'b101 && w[30], a, imm, 1'b0);
                    wr = 1'b1;
                end
                rv_pkg::OP_LOAD: begin
                    if (f3 == 3'b011) begin
                        addr = a + imm;
                        res = data_words[addr[10:3]];
                        wr = 1'b1;
                    end
                end
                rv_pkg::OP_BRANCH: begin
                    case (f3)
                        3'b000: taken = a == b;
                        3'b001: taken = a != b;
                        3'b100: taken = $signed(a) < $signed(b);
                        3'b101: taken = $signed(a) >= $signed(b);
                        3'b110: taken = a < b;
                        3'b111: taken = a >= b;
                        default: taken = 1'b0;
                    endcase
                    if (taken && boff == 0) begin
                        done = 1'b1;
                    end else if (taken) begin
                        next_idx = pc_idx + boff / 4;
                    end
                end
                default: begin
                end
            endcase
            if (wr && rd != 5'd0) begin
                r[rd] = res;
                exp_rd.push_back(rd);
                exp_value.push_back(res);
                exp_test.push_back(prog_test[pc_idx]);
                test_total[prog_test[pc_idx]] = test_total[prog_test[pc_idx]] + 1;
            end
            pc_idx = next_idx;
            steps = steps + 1;
        end
    endtask

    always @(posedge CLK) begin
        if (run_i) begin
            cycles <= cycles + 1;
        end
    end

    // writeback outputs settle after the rising edge
    always @(negedge CLK) begin
        int t;
        if (reset && wb_en_o) begin
            if (exp_idx >= exp_rd.size()) begin
                $display("unexpected writeback at %0t: x%0d = %h", $time, wb_rd_o, wb_value_o);
                errors = errors + 1;
                test_errors[NUM_TESTS - 1] = test_errors[NUM_TESTS - 1] + 1;
            end else begin
                t = exp_test[exp_idx];
                checks = checks + 1;
                if (wb_rd_o !== exp_rd[exp_idx] || wb_value_o !== exp_value[exp_idx]) begin
                    $display("mismatch at %0t: writeback %0d expected x%0d = %h, got x%0d = %h",
                             $time, exp_idx, exp_rd[exp_idx], exp_value[exp_idx],
                             wb_rd_o, wb_value_o);
                    errors = errors + 1;
                    test_errors[t] = test_errors[t] + 1;
                end
                test_seen[t] = test_seen[t] + 1;
                if (test_seen[t] == test_total[t]) begin
                    $display("test %0d %s: %0d writebacks, %0d errors",
                             t + 1, test_names[t], test_total[t], test_errors[t]);
                end
                exp_idx = exp_idx + 1;
            end
        end
    end

    initial begin
        reset = 1'b0;
        run_i = 1'b0;
        load_en_i = 1'b0;
        load_dmem_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        timed_out = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_seen[t] = 0;
            test_errors[t] = 0;
        end
        build_program();
        seed = 32'hf905d8c6;
        for (int i = 0; i < rv_pkg::DMEM_DEPTH; i++) begin
            seed = xorshift32(seed);
            data_words[i][63:32] = seed;
            seed = xorshift32(seed);
            data_words[i][31:0] = seed;
        end
        build_expected();
        repeat (4) @(negedge CLK);
        reset = 1'b1;
        // program plus a few trailing nops
        for (int i = 0; i < prog_len + 4; i++) begin
            @(negedge CLK);
            load_en_i = 1'b1;
            load_dmem_i = 1'b0;
            load_addr_i = rv_pkg::mem_addr_t'(i);
            load_data_i = {32'b0, prog[i]};
        end
        for (int i = 0; i < rv_pkg::DMEM_DEPTH; i++) begin
            @(negedge CLK);
            load_en_i = 1'b1;
            load_dmem_i = 1'b1;
            load_addr_i = rv_pkg::mem_addr_t'(i);
            load_data_i = data_words[i];
        end
        @(negedge CLK);
        load_en_i = 1'b0;
        load_dmem_i = 1'b0;
        run_i = 1'b1;
        limit = prog_len * 4 + 50;
        while (exp_idx < exp_rd.size() && cycles < limit) begin
            @(posedge CLK);
        end
        if (exp_idx < exp_rd.size()) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles, only %0d of %0d writebacks arrived",
                     cycles, exp_idx, exp_rd.size());
        end else begin
            // watch for stray writebacks once the program is parked
            repeat (10) @(posedge CLK);
        end
        for (int t = 0; t < NUM_TESTS - 1; t++) begin
            if (test_seen[t] < test_total[t]) begin
                $display("test %0d %s: %0d of %0d writebacks missing", t + 1, test_names[t],
                         test_total[t] - test_seen[t], test_total[t]);
            end
        end
        $display("test %0d %s: %0d of %0d writebacks, %0d errors", NUM_TESTS,
                 test_names[NUM_TESTS - 1], exp_idx, exp_rd.size(), test_errors[NUM_TESTS - 1]);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
source/rv_pkg.sv
source/inst_fetch.sv
source/inst_decode.sv
source/inst_execute.sv
source/data_memory.sv
source/rv_core.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
